//--- source/mem_hier_params.svh
`ifndef MEM_HIER_PARAMS_SVH
`define MEM_HIER_PARAMS_SVH

// line address width
`define ADDR_BITS 32

// every access moves one full line
`define CL_BITS 128

// 16 direct-mapped lines in the L2
`define LG_L2_LINES 4

`define CNT_BITS 64

`endif

//--- source/mem_hier_pkg.sv
`default_nettype none

package mem_hier_pkg;

   // matches the 4-bit opcode field of the memory port
   typedef enum logic [3:0] {
      MEM_LOAD  = 4'd0,
      MEM_STORE = 4'd1
   } mem_op_t;

   typedef enum logic [2:0] {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_t;

   typedef enum logic [2:0] {
      L2_IDLE       = 3'd0,
      L2_LOOKUP     = 3'd1,
      L2_WRITEBACK  = 3'd2,
      L2_FILL       = 3'd3,
      L2_RESPOND    = 3'd4,
      L2_FLUSH_SCAN = 3'd5,
      L2_FLUSH_WB   = 3'd6
   } l2_state_t;

endpackage

`default_nettype wire

//--- source/l2_req_if.sv
`default_nettype none
`include "mem_hier_params.svh"

interface l2_req_if
   import mem_hier_pkg::*;
   ();

   logic                  valid;      // held until done
   logic [`ADDR_BITS-1:0] addr;
   mem_op_t               op;
   logic [`CL_BITS-1:0]   store_data;
   logic                  done;       // one-cycle pulse
   logic [`CL_BITS-1:0]   load_data;

   modport arb (output valid, addr, op, store_data, input done, load_data);
   modport l2 (input valid, addr, op, store_data, output done, load_data);

endinterface

`default_nettype wire

//--- source/l1_arbiter.sv
`default_nettype none
`include "mem_hier_params.svh"

module l1_arbiter
   import mem_hier_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  l1i_req,
   input  logic [`ADDR_BITS-1:0] l1i_addr,
   input  logic                  l1d_req,
   input  logic [`ADDR_BITS-1:0] l1d_addr,
   input  mem_op_t               l1d_opcode,
   input  logic [`CL_BITS-1:0]   l1d_store_data,
   input  logic                  in_flush_mode,
   output logic                  l1i_rsp_valid,
   output logic                  l1d_rsp_valid,
   output logic [`CL_BITS-1:0]   load_data,
   l2_req_if.arb                 req
);

   logic                  r_valid;
   logic                  r_owner_d;
   logic                  r_block_i, r_block_d;
   logic [`ADDR_BITS-1:0] r_addr;
   mem_op_t               r_op;
   logic [`CL_BITS-1:0]   r_store_data;

   wire w_idle = !r_valid && !in_flush_mode;
   wire w_take_d = w_idle && l1d_req && !r_block_d;  // l1d wins a tie
   wire w_take_i = w_idle && l1i_req && !r_block_i && !w_take_d;

   assign req.valid = r_valid;
   assign req.addr = r_addr;
   assign req.op = r_op;
   assign req.store_data = r_store_data;

   assign l1i_rsp_valid = req.done && !r_owner_d;
   assign l1d_rsp_valid = req.done && r_owner_d;
   assign load_data = req.load_data;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid <= 1'b0;
         r_owner_d <= 1'b0;
         r_block_i <= 1'b0;
         r_block_d <= 1'b0;
      end
      else
      begin
         if (r_valid && req.done)
            r_valid <= 1'b0;
         else if (w_take_d || w_take_i)
         begin
            r_valid <= 1'b1;
            r_owner_d <= w_take_d;
         end
         // served requester must drop req once before it is taken again
         r_block_i <= l1i_req && (r_block_i || l1i_rsp_valid);
         r_block_d <= l1d_req && (r_block_d || l1d_rsp_valid);
      end
   end

   always_ff @(posedge clk)
   begin
      if (w_take_d)
      begin
         r_addr <= l1d_addr;
         r_op <= l1d_opcode;
         r_store_data <= l1d_store_data;
      end
      else if (w_take_i)
      begin
         r_addr <= l1i_addr;
         r_op <= MEM_LOAD;  // instruction side only reads
      end
   end

endmodule

`default_nettype wire

//--- source/flush_sequencer.sv
`default_nettype none

module flush_sequencer
   import mem_hier_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic flush_req_l1i,
   input  logic flush_req_l1d,
   input  logic l1i_flush_complete,
   input  logic l1d_flush_complete,
   input  logic l2_flush_done,
   output logic in_flush_mode,
   output logic l2_flush_start
);

   flush_state_t r_state, n_state;
   logic         r_flush, n_flush;
   logic         r_flush_l2, n_flush_l2;

   assign in_flush_mode = r_flush;
   assign l2_flush_start = r_flush_l2;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= FLUSH_IDLE;
         r_flush <= 1'b0;
         r_flush_l2 <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_flush <= n_flush;
         r_flush_l2 <= n_flush_l2;
      end
   end

   // GOT_x means x needs nothing more, the other L1 is still owed
   always_comb
   begin
      n_state = r_state;
      n_flush = r_flush;
      n_flush_l2 = 1'b0;
      case (r_state)
         FLUSH_IDLE:
         begin
            if (flush_req_l1i || flush_req_l1d)
               n_flush = 1'b1;
            if (flush_req_l1i && flush_req_l1d)
               n_state = WAIT_FOR_L1D_L1I;
            else if (flush_req_l1i)
               n_state = GOT_L1D;
            else if (flush_req_l1d)
               n_state = GOT_L1I;
         end
         WAIT_FOR_L1D_L1I:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
            else if (l1d_flush_complete)
               n_state = GOT_L1D;
            else if (l1i_flush_complete)
               n_state = GOT_L1I;
         end
         GOT_L1D:
         begin
            if (l1i_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         GOT_L1I:
         begin
            if (l1d_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         FLUSH_L2:
         begin
            if (l2_flush_done)
            begin
               n_state = FLUSH_IDLE;
               n_flush = 1'b0;  // drops the cycle after done
            end
         end
         default:
            n_state = FLUSH_IDLE;
      endcase
   end

endmodule

`default_nettype wire

//--- source/l2_cache.sv
`default_nettype none
`include "mem_hier_params.svh"

module l2_cache
   import mem_hier_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   l2_req_if.l2                  req,
   input  logic                  l2_flush_start,
   output logic                  l2_flush_done,
   output logic                  mem_req_valid,
   output logic [`ADDR_BITS-1:0] mem_req_addr,
   output logic [`CL_BITS-1:0]   mem_req_store_data,
   output mem_op_t               mem_req_opcode,
   input  logic                  mem_rsp_valid,
   input  logic [`CL_BITS-1:0]   mem_rsp_load_data,
   output logic [`CNT_BITS-1:0]  l2_cache_accesses,
   output logic [`CNT_BITS-1:0]  l2_cache_hits
);

   localparam L2_LINES = 1 << `LG_L2_LINES;
   localparam TAG_BITS = `ADDR_BITS - `LG_L2_LINES;

   l2_state_t               r_state, n_state;
   logic [L2_LINES-1:0]     r_line_valid, r_line_dirty;
   logic [TAG_BITS-1:0]     r_tag [0:L2_LINES-1];
   logic [`CL_BITS-1:0]     r_data [0:L2_LINES-1];
   logic [`LG_L2_LINES-1:0] r_scan_idx, n_scan_idx;
   logic                    r_flush_pend, r_flush_done;
   logic [`CL_BITS-1:0]     r_load_data;
   logic                    r_mem_req_valid;
   logic [`ADDR_BITS-1:0]   r_mem_addr;
   logic [`CL_BITS-1:0]     r_mem_data;
   mem_op_t                 r_mem_op;
   logic [`CNT_BITS-1:0]    r_accesses, r_hits;

   logic                    t_mem_req;
   logic [`ADDR_BITS-1:0]   t_mem_addr;
   logic [`CL_BITS-1:0]     t_mem_data;
   mem_op_t                 t_mem_op;
   logic                    t_fill, t_fill_dirty;
   logic [`CL_BITS-1:0]     t_fill_data;
   logic                    t_latch_load;
   logic [`CL_BITS-1:0]     t_load_value;
   logic                    t_count, t_count_hit;
   logic                    t_miss_next, t_scan_next;
   logic                    t_flush_begin, t_flush_end;

   wire [`LG_L2_LINES-1:0] w_idx = req.addr[`LG_L2_LINES-1:0];
   wire [TAG_BITS-1:0] w_tag = req.addr[`ADDR_BITS-1:`LG_L2_LINES];
   wire w_hit = r_line_valid[w_idx] && (r_tag[w_idx] == w_tag);
   wire w_victim_dirty = r_line_valid[w_idx] && r_line_dirty[w_idx];
   wire w_scan_dirty = r_line_valid[r_scan_idx] && r_line_dirty[r_scan_idx];

   assign req.done = (r_state == L2_RESPOND);
   assign req.load_data = r_load_data;
   assign l2_flush_done = r_flush_done;
   assign mem_req_valid = r_mem_req_valid;
   assign mem_req_addr = r_mem_addr;
   assign mem_req_store_data = r_mem_data;
   assign mem_req_opcode = r_mem_op;
   assign l2_cache_accesses = r_accesses;
   assign l2_cache_hits = r_hits;

   always_comb
   begin
      n_state = r_state;
      n_scan_idx = r_scan_idx;
      t_mem_req = 1'b0;
      t_mem_addr = req.addr;
      t_mem_data = req.store_data;
      t_mem_op = MEM_LOAD;
      t_fill = 1'b0;
      t_fill_dirty = 1'b0;
      t_fill_data = req.store_data;
      t_latch_load = 1'b0;
      t_load_value = r_data[w_idx];
      t_count = 1'b0;
      t_count_hit = 1'b0;
      t_miss_next = 1'b0;
      t_scan_next = 1'b0;
      t_flush_begin = 1'b0;
      t_flush_end = 1'b0;
      case (r_state)
         L2_IDLE:
         begin
            if (req.valid)
               n_state = L2_LOOKUP;
            else if (r_flush_pend)
            begin
               t_flush_begin = 1'b1;
               n_scan_idx = '0;
               n_state = L2_FLUSH_SCAN;
            end
         end
         L2_LOOKUP:
         begin
            t_count = 1'b1;
            if (w_hit)
            begin
               t_count_hit = 1'b1;
               n_state = L2_RESPOND;
               if (req.op == MEM_STORE)
               begin
                  t_fill = 1'b1;
                  t_fill_dirty = 1'b1;
               end
               else
                  t_latch_load = 1'b1;
            end
            else if (w_victim_dirty)
            begin
               t_mem_req = 1'b1;  // evict first
               t_mem_addr = {r_tag[w_idx], w_idx};
               t_mem_data = r_data[w_idx];
               t_mem_op = MEM_STORE;
               n_state = L2_WRITEBACK;
            end
            else
               t_miss_next = 1'b1;
         end
         L2_WRITEBACK:
            t_miss_next = mem_rsp_valid;
         L2_FILL:
         begin
            if (mem_rsp_valid)
            begin
               t_fill = 1'b1;
               t_fill_data = mem_rsp_load_data;
               t_latch_load = 1'b1;
               t_load_value = mem_rsp_load_data;
               n_state = L2_RESPOND;
            end
         end
         L2_RESPOND:
            n_state = L2_IDLE;
         L2_FLUSH_SCAN:
         begin
            if (w_scan_dirty)
            begin
               t_mem_req = 1'b1;
               t_mem_addr = {r_tag[r_scan_idx], r_scan_idx};
               t_mem_data = r_data[r_scan_idx];
               t_mem_op = MEM_STORE;
               n_state = L2_FLUSH_WB;
            end
            else
               t_scan_next = 1'b1;
         end
         L2_FLUSH_WB:
         begin
            if (mem_rsp_valid)
            begin
               n_state = L2_FLUSH_SCAN;
               t_scan_next = 1'b1;
            end
         end
         default:
            n_state = L2_IDLE;
      endcase

      if (t_miss_next)
      begin
         if (req.op == MEM_STORE)
         begin
            t_fill = 1'b1;  // full line store, nothing to fetch
            t_fill_dirty = 1'b1;
            n_state = L2_RESPOND;
         end
         else
         begin
            t_mem_req = 1'b1;
            n_state = L2_FILL;
         end
      end

      if (t_scan_next)
      begin
         if (&r_scan_idx)
         begin
            t_flush_end = 1'b1;
            n_state = L2_IDLE;
         end
         else
            n_scan_idx = r_scan_idx + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= L2_IDLE;
         r_line_valid <= '0;
         r_line_dirty <= '0;
         r_scan_idx <= '0;
         r_flush_pend <= 1'b0;
         r_flush_done <= 1'b0;
         r_mem_req_valid <= 1'b0;
         r_accesses <= '0;
         r_hits <= '0;
      end
      else
      begin
         r_state <= n_state;
         r_scan_idx <= n_scan_idx;
         r_flush_done <= t_flush_end;
         r_mem_req_valid <= t_mem_req;
         if (l2_flush_start)
            r_flush_pend <= 1'b1;  // may arrive while a request is in service
         else if (t_flush_begin)
            r_flush_pend <= 1'b0;
         if (t_count)
            r_accesses <= r_accesses + 1'b1;
         if (t_count_hit)
            r_hits <= r_hits + 1'b1;
         if (t_fill)
         begin
            r_line_valid[w_idx] <= 1'b1;
            r_line_dirty[w_idx] <= t_fill_dirty;
         end
         if (t_scan_next)
         begin
            r_line_valid[r_scan_idx] <= 1'b0;
            r_line_dirty[r_scan_idx] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (t_fill)
      begin
         r_tag[w_idx] <= w_tag;
         r_data[w_idx] <= t_fill_data;
      end
      if (t_latch_load)
         r_load_data <= t_load_value;
      if (t_mem_req)
      begin
         r_mem_addr <= t_mem_addr;
         r_mem_data <= t_mem_data;
         r_mem_op <= t_mem_op;
      end
   end

endmodule

`default_nettype wire

//--- source/mem_hier.sv
`default_nettype none
`include "mem_hier_params.svh"

module mem_hier
   import mem_hier_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  l1i_req,
   input  logic [`ADDR_BITS-1:0] l1i_addr,
   input  logic                  l1d_req,
   input  logic [`ADDR_BITS-1:0] l1d_addr,
   input  mem_op_t               l1d_opcode,
   input  logic [`CL_BITS-1:0]   l1d_store_data,
   output logic                  l1i_rsp_valid,
   output logic                  l1d_rsp_valid,
   output logic [`CL_BITS-1:0]   load_data,
   input  logic                  flush_req_l1i,
   input  logic                  flush_req_l1d,
   input  logic                  l1i_flush_complete,
   input  logic                  l1d_flush_complete,
   output logic                  in_flush_mode,
   output logic                  l2_flush_done,
   output logic                  mem_req_valid,
   output logic [`ADDR_BITS-1:0] mem_req_addr,
   output logic [`CL_BITS-1:0]   mem_req_store_data,
   output mem_op_t               mem_req_opcode,
   input  logic                  mem_rsp_valid,
   input  logic [`CL_BITS-1:0]   mem_rsp_load_data,
   output logic [`CNT_BITS-1:0]  l2_cache_accesses,
   output logic [`CNT_BITS-1:0]  l2_cache_hits
);

   logic l2_flush_start;

   l2_req_if l2_req ();

   l1_arbiter arb (
      .clk(clk),
      .reset(reset),
      .l1i_req(l1i_req),
      .l1i_addr(l1i_addr),
      .l1d_req(l1d_req),
      .l1d_addr(l1d_addr),
      .l1d_opcode(l1d_opcode),
      .l1d_store_data(l1d_store_data),
      .in_flush_mode(in_flush_mode),
      .l1i_rsp_valid(l1i_rsp_valid),
      .l1d_rsp_valid(l1d_rsp_valid),
      .load_data(load_data),
      .req(l2_req)
   );

   flush_sequencer flush_seq (
      .clk(clk),
      .reset(reset),
      .flush_req_l1i(flush_req_l1i),
      .flush_req_l1d(flush_req_l1d),
      .l1i_flush_complete(l1i_flush_complete),
      .l1d_flush_complete(l1d_flush_complete),
      .l2_flush_done(l2_flush_done),
      .in_flush_mode(in_flush_mode),
      .l2_flush_start(l2_flush_start)
   );

   l2_cache l2cache (
      .clk(clk),
      .reset(reset),
      .req(l2_req),
      .l2_flush_start(l2_flush_start),
      .l2_flush_done(l2_flush_done),
      .mem_req_valid(mem_req_valid),
      .mem_req_addr(mem_req_addr),
      .mem_req_store_data(mem_req_store_data),
      .mem_req_opcode(mem_req_opcode),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp_load_data(mem_rsp_load_data),
      .l2_cache_accesses(l2_cache_accesses),
      .l2_cache_hits(l2_cache_hits)
   );

endmodule

`default_nettype wire

//--- testbench/mem_hier_checker.sv
`default_nettype none
`include "mem_hier_params.svh"

module mem_hier_checker
   import mem_hier_pkg::*;
(
   input logic                  clk,
   input logic                  reset,
   input logic                  l1i_req,
   input logic [`ADDR_BITS-1:0] l1i_addr,
   input logic                  l1d_req,
   input logic [`ADDR_BITS-1:0] l1d_addr,
   input mem_op_t               l1d_opcode,
   input logic [`CL_BITS-1:0]   l1d_store_data,
   input logic                  l1i_rsp_valid,
   input logic                  l1d_rsp_valid,
   input logic [`CL_BITS-1:0]   load_data,
   input logic                  flush_req_l1i,
   input logic                  flush_req_l1d,
   input logic                  l1i_flush_complete,
   input logic                  l1d_flush_complete,
   input logic                  in_flush_mode,
   input logic                  l2_flush_start,
   input logic                  l2_flush_done,
   input logic                  mem_req_valid,
   input logic [`ADDR_BITS-1:0] mem_req_addr,
   input logic [`CL_BITS-1:0]   mem_req_store_data,
   input mem_op_t               mem_req_opcode,
   input logic [`CNT_BITS-1:0]  l2_cache_accesses,
   input logic [`CNT_BITS-1:0]  l2_cache_hits
);

   localparam TAG_BITS = `ADDR_BITS - `LG_L2_LINES;

   int                   error_count = 0;
   int                   check_count = 0;
   int                   k;
   logic [`CL_BITS-1:0]  shadow [0:63];     // last value stored per line
   logic [`CL_BITS-1:0]  model_mem [0:63];
   logic [15:0]          m_valid, m_dirty;
   logic [TAG_BITS-1:0]  m_tag [0:15];
   logic [`CNT_BITS-1:0] n_access, n_hit;
   logic                 prev_reset, prev_flush_req, exp_start, flush_ended;
   logic                 got_i, got_d, i_served, d_served, dual;
   logic [3:0]           wb_idx;

   function automatic logic [`CL_BITS-1:0] init_line(input logic [`ADDR_BITS-1:0] a);
      return {a, ~a, a ^ 32'h9e37_79b9, a[15:0], a[31:16]};
   endfunction

   task automatic report_mismatch(input string what, input logic [`CL_BITS-1:0] exp,
                                  input logic [`CL_BITS-1:0] act);
      check_count++;
      if (exp !== act)
      begin
         error_count++;
         $display("mismatch %s %s: expected %0h, actual %0h",
                  tb_mem_hier.test_name, what, exp, act);
      end
   endtask

   task automatic report_error(input string msg);
      error_count++;
      $display("error in %s: %s", tb_mem_hier.test_name, msg);
   endtask

   // replays one completed request on the model
   task automatic check_access(input logic [`ADDR_BITS-1:0] addr, input mem_op_t op,
                               input logic [`CL_BITS-1:0] data);
      logic [3:0]          idx;
      logic [TAG_BITS-1:0] tag;
      logic                hit;
      idx = addr[3:0];
      tag = addr[`ADDR_BITS-1:4];
      hit = m_valid[idx] && (m_tag[idx] == tag);
      n_access++;
      if (hit)
         n_hit++;
      if (op == MEM_STORE)
      begin
         shadow[addr[5:0]] = data;
         m_dirty[idx] = 1'b1;
      end
      else
      begin
         report_mismatch("load_data", shadow[addr[5:0]], load_data);
         if (!hit)
            m_dirty[idx] = 1'b0;  // fresh fill is clean
      end
      m_valid[idx] = 1'b1;
      m_tag[idx] = tag;
      report_mismatch("l2_cache_accesses", n_access, l2_cache_accesses);
      report_mismatch("l2_cache_hits", n_hit, l2_cache_hits);
   endtask

   initial
   begin
      for (k = 0; k < 64; k++)
      begin
         shadow[k] = init_line(32'h0001_0000 + k);
         model_mem[k] = init_line(32'h0001_0000 + k);
      end
   end

   always @(posedge clk)
   begin
      if (reset)
      begin
         m_valid = '0;
         m_dirty = '0;
         n_access = '0;
         n_hit = '0;
         prev_reset = 1'b1;
         {prev_flush_req, exp_start, flush_ended} = '0;
         {got_i, got_d, i_served, d_served, dual} = '0;
      end
      else
      begin
         if (prev_reset)
         begin
            if (in_flush_mode || l2_flush_done || mem_req_valid)
               report_error("control output high after reset");
            if (l1i_rsp_valid || l1d_rsp_valid)
               report_error("response pulse right after reset");
            report_mismatch("accesses after reset", '0, l2_cache_accesses);
            report_mismatch("hits after reset", '0, l2_cache_hits);
         end
         if (l1i_req && l1d_req && !i_served && !d_served && !dual &&
             (l1i_rsp_valid || l1d_rsp_valid) == 1'b0)
            dual = 1'b1;
         if ((l1i_rsp_valid || l1d_rsp_valid) && in_flush_mode)
            report_error("L1 response while in flush mode");
         if (l1d_rsp_valid)
         begin
            if (!l1d_req || d_served)
               report_error("l1d response without a pending l1d request");
            else
               check_access(l1d_addr, l1d_opcode, l1d_store_data);
            d_served = 1'b1;
            dual = 1'b0;  // l1i may go next
         end
         if (l1i_rsp_valid)
         begin
            if (!l1i_req || i_served)
               report_error("l1i response without a pending l1i request");
            else
               check_access(l1i_addr, MEM_LOAD, '0);
            if (dual)
               report_error("l1i served before the pending l1d request");
            i_served = 1'b1;
         end
         if (!l1i_req)
            i_served = 1'b0;
         if (!l1d_req)
            d_served = 1'b0;
         if (!l1i_req && !l1d_req)
            dual = 1'b0;

         if (mem_req_valid && mem_req_opcode == MEM_STORE)
         begin
            wb_idx = mem_req_addr[3:0];
            if (!(m_valid[wb_idx] && m_dirty[wb_idx] && {m_tag[wb_idx], wb_idx} == mem_req_addr))
               report_error("write-back of a clean or absent line");
            else
            begin
               report_mismatch("write-back data", shadow[mem_req_addr[5:0]], mem_req_store_data);
               model_mem[mem_req_addr[5:0]] = shadow[mem_req_addr[5:0]];
               m_dirty[wb_idx] = 1'b0;
            end
         end

         if (prev_flush_req && !in_flush_mode)
            report_error("in_flush_mode did not rise after a flush request");
         if (exp_start)
         begin
            if (!l2_flush_start)
               report_error("l2_flush_start missing one cycle after the last L1 completion");
            exp_start = 1'b0;
         end
         else if (l2_flush_start)
            report_error("unexpected l2_flush_start");
         if (in_flush_mode)
         begin
            got_i = got_i || l1i_flush_complete;
            got_d = got_d || l1d_flush_complete;
            if (got_i && got_d && (l1i_flush_complete || l1d_flush_complete))
               exp_start = 1'b1;
         end
         if (flush_ended && in_flush_mode)
            report_error("in_flush_mode still high the cycle after l2_flush_done");
         flush_ended = 1'b0;
         if (l2_flush_done)
         begin
            flush_ended = 1'b1;
            got_i = 1'b0;
            got_d = 1'b0;
            if (!in_flush_mode)
               report_error("in_flush_mode low at l2_flush_done");
            if (m_dirty != '0)
               report_error("dirty lines left after the L2 flush");
            m_valid = '0;
            m_dirty = '0;
            for (k = 0; k < 64; k++)
               report_mismatch("memory after flush", model_mem[k], tb_mem_hier.mem_lines[k]);
         end
         prev_flush_req = flush_req_l1i || flush_req_l1d;
         prev_reset = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_mem_hier.sv
`default_nettype none
`include "mem_hier_params.svh"

module tb_mem_hier
   import mem_hier_pkg::*;
   ();

   localparam N_RAND = 80;
   localparam N_DUAL = 10;
   localparam N_FLUSH = 2;
   localparam LIMIT = 40 * (2 * N_RAND + 2 * N_DUAL + N_FLUSH) + 200 * N_FLUSH + 20;

   logic                  clk, reset;
   logic                  l1i_req, l1d_req;
   logic [`ADDR_BITS-1:0] l1i_addr, l1d_addr;
   mem_op_t               l1d_opcode;
   logic [`CL_BITS-1:0]   l1d_store_data;
   logic                  l1i_rsp_valid, l1d_rsp_valid;
   logic [`CL_BITS-1:0]   load_data;
   logic                  flush_req_l1i, flush_req_l1d;
   logic                  l1i_flush_complete, l1d_flush_complete;
   logic                  in_flush_mode, l2_flush_start, l2_flush_done;
   logic                  mem_req_valid, mem_rsp_valid;
   logic [`ADDR_BITS-1:0] mem_req_addr;
   logic [`CL_BITS-1:0]   mem_req_store_data, mem_rsp_load_data;
   mem_op_t               mem_req_opcode;
   logic [`CNT_BITS-1:0]  l2_cache_accesses, l2_cache_hits;

   logic [`CL_BITS-1:0]   mem_lines [0:63];  // external memory, line 0x10000 + slot
   logic [31:0]           rng_state = 32'd4162;
   int                    cycle_count = 0;
   int                    n;
   string                 test_name = "reset";

   mem_hier dut (.*);

   assign l2_flush_start = dut.l2_flush_start;  // internal pulse, watched only

   mem_hier_checker chk (.*);

   function automatic logic [31:0] next_rand();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   // 64 lines, 4 tags per index, so both hits and conflicts occur
   function automatic logic [`ADDR_BITS-1:0] pick_addr();
      return 32'h0001_0000 + (next_rand() & 32'h3f);
   endfunction

   function automatic logic [`CL_BITS-1:0] init_line(input logic [`ADDR_BITS-1:0] a);
      return {a, ~a, a ^ 32'h9e37_79b9, a[15:0], a[31:16]};
   endfunction

   task automatic issue(input logic use_i, input logic use_d);
      if (use_i)
      begin
         l1i_addr = pick_addr();
         l1i_req = 1'b1;
      end
      if (use_d)
      begin
         l1d_addr = pick_addr();
         l1d_opcode = (next_rand() & 1) ? MEM_STORE : MEM_LOAD;
         l1d_store_data = {next_rand(), next_rand(), next_rand(), next_rand()};
         l1d_req = 1'b1;
      end
   endtask

   // hold each req until its own response, then drop it a cycle later
   task automatic await_rsp(input logic use_i, input logic use_d);
      logic i_pend, d_pend;
      i_pend = use_i;
      d_pend = use_d;
      while (i_pend || d_pend)
      begin
         @(posedge clk);
         #1;
         if (!i_pend)
            l1i_req = 1'b0;
         if (!d_pend)
            l1d_req = 1'b0;
         if (l1i_rsp_valid)
            i_pend = 1'b0;
         if (l1d_rsp_valid)
            d_pend = 1'b0;
      end
      @(posedge clk);
      #1;
      l1i_req = 1'b0;
      l1d_req = 1'b0;
      @(posedge clk);  // low for a full cycle before the next request
      #1;
   endtask

   task automatic pulse_complete(input logic do_i, input logic do_d);
      repeat (1 + next_rand() % 4) @(posedge clk);
      #1;
      l1i_flush_complete = do_i;
      l1d_flush_complete = do_d;
      @(posedge clk);
      #1;
      l1i_flush_complete = 1'b0;
      l1d_flush_complete = 1'b0;
   endtask

   // an l1i request is held through the flush and must wait for its end
   task automatic run_flush();
      int order;
      order = next_rand() % 3;
      flush_req_l1i = 1'b1;
      flush_req_l1d = 1'b1;
      @(posedge clk);
      #1;
      flush_req_l1i = 1'b0;
      flush_req_l1d = 1'b0;
      issue(1'b1, 1'b0);
      if (order == 2)
         pulse_complete(1'b1, 1'b1);
      else
      begin
         pulse_complete(order == 1, order == 0);
         pulse_complete(order == 0, order == 1);
      end
      do
      begin
         @(posedge clk);
         #1;
      end
      while (!l2_flush_done);
      await_rsp(1'b1, 1'b0);
   endtask

   task automatic run_random(input int count);
      int choice;
      repeat (count)
      begin
         choice = next_rand() % 4;
         issue(choice == 0 || choice == 3, choice != 0);
         await_rsp(choice == 0 || choice == 3, choice != 0);
      end
   endtask

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // memory side: one request at a time, answered after 1 to 6 cycles
   initial
   begin
      int delay;
      logic [5:0] slot;
      mem_rsp_valid = 1'b0;
      mem_rsp_load_data = '0;
      for (n = 0; n < 64; n++)
         mem_lines[n] = init_line(32'h0001_0000 + n);
      forever
      begin
         @(posedge clk);
         if (mem_req_valid)
         begin
            delay = 1 + next_rand() % 6;
            slot = mem_req_addr[5:0];
            if (mem_req_opcode == MEM_STORE)
               mem_lines[slot] = mem_req_store_data;
            repeat (delay - 1) @(posedge clk);
            #1;
            mem_rsp_load_data = mem_lines[slot];
            mem_rsp_valid = 1'b1;
            @(posedge clk);
            #1 mem_rsp_valid = 1'b0;
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count > LIMIT)
      begin
         $display("timeout: run exceeded %0d cycles in %s", LIMIT, test_name);
         $display("Simulation failed");
         $finish;
      end
   end

   initial
   begin
      reset = 1'b1;
      {l1i_req, l1d_req, flush_req_l1i, flush_req_l1d} = '0;
      {l1i_flush_complete, l1d_flush_complete} = '0;
      l1i_addr = '0;
      l1d_addr = '0;
      l1d_opcode = MEM_LOAD;
      l1d_store_data = '0;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      test_name = "random";
      run_random(N_RAND / 2);
      test_name = "flush";
      run_flush();
      test_name = "dual";
      repeat (N_DUAL)
      begin
         issue(1'b1, 1'b1);
         await_rsp(1'b1, 1'b1);
      end
      test_name = "random";
      run_random(N_RAND / 2);
      test_name = "final flush";
      run_flush();
      repeat (3) @(posedge clk);
      $display("checks %0d, errors %0d", chk.check_count, chk.error_count);
      if (chk.error_count == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- mem_hier.f
+incdir+source
source/mem_hier_pkg.sv
source/l2_req_if.sv
source/l1_arbiter.sv
source/flush_sequencer.sv
source/l2_cache.sv
source/mem_hier.sv
testbench/mem_hier_checker.sv
testbench/tb_mem_hier.sv
